/* verilog/fifo_settings.svh */
// Loopback exerciser sizes
`ifndef FIFO_SETTINGS_SVH
`define FIFO_SETTINGS_SVH

// full test word, as seen by the FIFO
`define FIFO_DATA_W 80

// one counter lane, wraps modulo 1024
`define FIFO_LANE_W 10

// lanes per word, LANES * LANE_W == DATA_W
`define FIFO_LANES 8

// entries in the FIFO, power of two
`define FIFO_DEPTH 16

`endif

/* verilog/fifo_pkg.sv */
// Loopback exerciser types
`include "fifo_settings.svh"

package fifo_pkg;

  // fixed pattern codes
  typedef enum logic [3:0] {
    pat_user = 4'd0, // word taken from user_word
    pat_up   = 4'd1, // lanes count up
    pat_down = 4'd2, // lanes count down
    pat_zero = 4'd3, // all zero
    pat_one  = 4'd4, // all one
    pat_chk  = 4'd5, // 10/01 checkerboard
    pat_chkb = 4'd6, // inverse checkerboard
    pat_abc  = 4'd7, // ascii ABCDEFGH
    pat_alt  = 4'd8, // 00/11 alternating
    pat_altb = 4'd9  // inverse alternating
  } pat_mode_t;      // unused codes 10..15 give zero

  // two views of one 80-bit test word
  typedef union packed {
    logic [`FIFO_LANES-1:0][`FIFO_LANE_W-1:0] lanes; // counter lanes with lane 0 at lsb
    logic [`FIFO_DATA_W/8-1:0][7:0]           bytes; // bytes with byte 0 at lsb
  } test_word_u;

endpackage

/* verilog/pattern_gen.sv */
// Test word generator
`include "fifo_settings.svh"

module pattern_gen (
  input  logic                      clk,
  input  logic                      grstb,     // sync, active low
  input  logic                      load,      // restart with mode
  input  fifo_pkg::pat_mode_t       mode,
  input  logic [`FIFO_DATA_W-1:0]   user_word,
  input  logic                      advance,   // current word consumed
  output fifo_pkg::test_word_u      word
);

  import fifo_pkg::*;

  localparam int BYTES = `FIFO_DATA_W / 8;

  pat_mode_t                mode_q;  // latched pattern code
  logic [`FIFO_LANE_W-1:0]  base_q;  // counter base, steps by lane count
  logic                     phase_q; // odd/even word

  // state only moves on load or advance
  always_ff @(posedge clk)
  begin
    if (!grstb)
    begin
      mode_q  <= pat_up; // up counter after reset
      base_q  <= '0;
      phase_q <= 1'b0;
    end
    else if (load)
    begin
      mode_q  <= mode;
      base_q  <= '0;
      phase_q <= 1'b0;
    end
    else if (advance)
    begin
      phase_q <= ~phase_q; // alternating modes flip per word
      if (mode_q == pat_down)
        base_q <= base_q - `FIFO_LANE_W'(`FIFO_LANES);
      else
        base_q <= base_q + `FIFO_LANE_W'(`FIFO_LANES);
    end
  end

  // word decode, purely from state
  always_comb
  begin
    word = '0; // unused codes and zero mode
    case (mode_q)
      pat_up:
      begin
        for (int i = 0; i < `FIFO_LANES; i++)
          word.lanes[i] = base_q + `FIFO_LANE_W'(i + 1); // wraps at 1024
      end
      pat_down:
      begin
        for (int i = 0; i < `FIFO_LANES; i++)
          word.lanes[i] = base_q - `FIFO_LANE_W'(i + 1); // wraps below 0
      end
      pat_zero: word = '0;
      pat_one:  word = '1;
      pat_chk:
      begin
        if (phase_q)
          word = {(`FIFO_DATA_W/2){2'b01}};
        else
          word = {(`FIFO_DATA_W/2){2'b10}};
      end
      pat_chkb:
      begin
        if (phase_q)
          word = {(`FIFO_DATA_W/2){2'b10}};
        else
          word = {(`FIFO_DATA_W/2){2'b01}};
      end
      pat_alt:
      begin
        if (phase_q)
          word = {(`FIFO_DATA_W/2){2'b11}};
        else
          word = {(`FIFO_DATA_W/2){2'b00}};
      end
      pat_altb:
      begin
        if (phase_q)
          word = {(`FIFO_DATA_W/2){2'b00}};
        else
          word = {(`FIFO_DATA_W/2){2'b11}};
      end
      pat_abc:
      begin
        // 'A' in the top byte down to 'H', low bytes stay zero
        for (int i = 0; i < 8; i++)
          word.bytes[BYTES-1-i] = 8'h41 + 8'(i);
      end
      pat_user: word = user_word;
      default:  word = '0;
    endcase
  end

endmodule

/* verilog/sync_fifo.sv */
// Synchronous FIFO
`include "fifo_settings.svh"

module sync_fifo (
  input  logic                    clk,
  input  logic                    grstb,    // sync, active low
  input  logic                    flush,    // drop everything, one cycle
  input  logic                    wr_en,
  input  logic [`FIFO_DATA_W-1:0] wr_data,
  input  logic                    rd_en,
  output logic [`FIFO_DATA_W-1:0] rd_data,  // valid with rd_valid
  output logic                    rd_valid,
  output logic                    full,
  output logic                    empty
);

  localparam int AW = $clog2(`FIFO_DEPTH); // address bits
  localparam int PW = AW + 1;              // pointer bits incl. wrap

  logic [`FIFO_DATA_W-1:0] mem [`FIFO_DEPTH]; // storage, no reset

  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [PW-1:0] wr_ptr_nxt;
  logic [PW-1:0] rd_ptr_nxt;
  logic          wr_accept;
  logic          rd_accept;

  assign wr_accept = wr_en && !full && !flush;  // full is registered
  assign rd_accept = rd_en && !empty && !flush; // no stale read across flush

  always_comb
  begin
    if (flush)
    begin
      wr_ptr_nxt = '0;
      rd_ptr_nxt = '0;
    end
    else
    begin
      wr_ptr_nxt = wr_ptr_q + PW'(wr_accept);
      rd_ptr_nxt = rd_ptr_q + PW'(rd_accept);
    end
  end

  // pointers and levels
  always_ff @(posedge clk)
  begin
    if (!grstb)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      full     <= 1'b0;
      empty    <= 1'b1;
      rd_valid <= 1'b0;
    end
    else
    begin
      wr_ptr_q <= wr_ptr_nxt;
      rd_ptr_q <= rd_ptr_nxt;
      empty    <= (wr_ptr_nxt == rd_ptr_nxt);                              // same lap
      full     <= (wr_ptr_nxt == {~rd_ptr_nxt[AW], rd_ptr_nxt[AW-1:0]}); // one lap ahead
      rd_valid <= rd_accept; // one-cycle pulse per read
    end
  end

  // data path
  always_ff @(posedge clk)
  begin
    if (wr_accept)
      mem[wr_ptr_q[AW-1:0]] <= wr_data;
    if (rd_accept)
      rd_data <= mem[rd_ptr_q[AW-1:0]]; // registered read
  end

endmodule

/* verilog/pattern_check.sv */
// Read data checker
`include "fifo_settings.svh"

module pattern_check (
  input  logic                    clk,
  input  logic                    grstb,      // sync, active low
  input  logic                    load,       // restart with mode
  input  fifo_pkg::pat_mode_t     mode,
  input  logic [`FIFO_DATA_W-1:0] user_word,
  input  logic                    rd_valid,   // one word out of the FIFO
  input  logic [`FIFO_DATA_W-1:0] rd_data,
  output logic                    err,        // sticky until load
  output logic [15:0]             err_count,
  output logic [15:0]             word_count
);

  import fifo_pkg::*;

  test_word_u exp_word; // expected word from the local copy
  logic       mismatch;

  // local generator copy, steps once per word read
  pattern_gen i_pattern_gen (
    .clk       (clk),
    .grstb     (grstb),
    .load      (load),
    .mode      (mode),
    .user_word (user_word),
    .advance   (rd_valid),
    .word      (exp_word)
  );

  assign mismatch = (rd_data != exp_word);

  // counts land one cycle after rd_valid
  always_ff @(posedge clk)
  begin
    if (!grstb)
    begin
      err        <= 1'b0;
      err_count  <= '0;
      word_count <= '0;
    end
    else if (load)
    begin
      // words still in flight at load belong to the old mode
      err        <= 1'b0;
      err_count  <= '0;
      word_count <= '0;
    end
    else if (rd_valid)
    begin
      word_count <= word_count + 16'd1; // wraps
      if (mismatch)
      begin
        err <= 1'b1;
        if (err_count != '1)
          err_count <= err_count + 16'd1; // saturates
      end
    end
  end

endmodule

/* verilog/fifo_loopback_top.sv */
// FIFO loopback exerciser
`include "fifo_settings.svh"

module fifo_loopback_top (
  input  logic                    clk,
  input  logic                    grstb,      // sync, active low
  input  fifo_pkg::pat_mode_t     pat_sel,
  input  logic [`FIFO_DATA_W-1:0] user_word,
  input  logic                    mode_load,  // restart gen, checker, flush FIFO
  input  logic                    wr_en,
  input  logic                    rd_en,
  output logic [`FIFO_DATA_W-1:0] rd_data,
  output logic                    rd_valid,
  output logic                    full,
  output logic                    empty,
  output logic                    err,
  output logic [15:0]             err_count,
  output logic [15:0]             word_count
);

  import fifo_pkg::*;

  test_word_u gen_word;   // word presented to the FIFO
  logic       wr_accept;  // generator moves on only when written

  assign wr_accept = wr_en && !full;

  pattern_gen i_pattern_gen (
    .clk       (clk),
    .grstb     (grstb),
    .load      (mode_load),
    .mode      (pat_sel),
    .user_word (user_word),
    .advance   (wr_accept),
    .word      (gen_word)
  );

  sync_fifo i_sync_fifo (
    .clk      (clk),
    .grstb    (grstb),
    .flush    (mode_load),
    .wr_en    (wr_en),   // fullness tested inside
    .wr_data  (gen_word),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .full     (full),
    .empty    (empty)
  );

  pattern_check i_pattern_check (
    .clk        (clk),
    .grstb      (grstb),
    .load       (mode_load),
    .mode       (pat_sel),
    .user_word  (user_word),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .err        (err),
    .err_count  (err_count),
    .word_count (word_count)
  );

endmodule

/* dv/fifo_loopback_assert.sv */
// Loopback data and level checks
`include "fifo_settings.svh"

module fifo_loopback_assert (
  input logic                    clk,
  input logic                    grstb,
  input fifo_pkg::pat_mode_t     pat_sel,
  input logic [`FIFO_DATA_W-1:0] user_word,
  input logic                    mode_load,
  input logic                    wr_en,
  input logic                    rd_en,
  input logic [`FIFO_DATA_W-1:0] rd_data,
  input logic                    rd_valid,
  input logic                    full,
  input logic                    empty,
  input logic                    err,
  input logic [15:0]             err_count,
  input logic [15:0]             word_count
);
  timeunit 1ns;
  timeprecision 100ps;
  import fifo_pkg::*;

  localparam int WRAP = 1 << `FIFO_LANE_W; // lane modulus of 1024

  pat_mode_t   m_mode;         // reference model state
  int          m_base;         // counter base in 0..WRAP-1
  logic        m_phase;        // even/odd word read
  int          m_words;        // rd_valid pulses since load
  int          m_occ;          // words held in the FIFO
  test_word_u  m_exp;          // next word expected on rd_valid
  int unsigned fail_count = 0; // polled by the testbench

  // model moves on words read and ignores writes
  always_ff @(posedge clk)
  begin
    if (!grstb || mode_load)
    begin
      m_mode  <= grstb ? pat_sel : pat_up; // reset picks up counter
      m_base  <= 0;
      m_phase <= 1'b0;
      m_words <= 0;
      m_occ   <= 0;                        // flush on load
    end
    else
    begin
      if (rd_valid)
      begin
        if (m_mode == pat_down)
          m_base <= (m_base + WRAP - `FIFO_LANES) % WRAP;
        else
          m_base <= (m_base + `FIFO_LANES) % WRAP;
        m_phase <= !m_phase;
        m_words <= m_words + 1;
      end
      m_occ <= m_occ + int'(wr_en && m_occ < `FIFO_DEPTH) - int'(rd_en && m_occ > 0);
    end
  end

  // expected word from the mode rules
  always_comb
  begin
    m_exp = '0;
    case (m_mode)
      pat_up:
        for (int i = 0; i < `FIFO_LANES; i++)
          m_exp.lanes[i] = `FIFO_LANE_W'((m_base + i + 1) % WRAP);
      pat_down:
        for (int i = 0; i < `FIFO_LANES; i++)
          m_exp.lanes[i] = `FIFO_LANE_W'((m_base + WRAP - i - 1) % WRAP);
      pat_one:  m_exp = '1;
      pat_chk:  m_exp = m_phase ? {(`FIFO_DATA_W/8){8'h55}} : {(`FIFO_DATA_W/8){8'haa}};
      pat_chkb: m_exp = m_phase ? {(`FIFO_DATA_W/8){8'haa}} : {(`FIFO_DATA_W/8){8'h55}};
      pat_alt:  m_exp = m_phase ? {(`FIFO_DATA_W/8){8'hff}} : {(`FIFO_DATA_W/8){8'h00}};
      pat_altb: m_exp = m_phase ? {(`FIFO_DATA_W/8){8'h00}} : {(`FIFO_DATA_W/8){8'hff}};
      pat_abc:  m_exp = {"ABCDEFGH", {(`FIFO_DATA_W-64){1'b0}}}; // letters in top bytes
      pat_user: m_exp = user_word;
      default:  m_exp = '0; // zero mode and unused codes
    endcase
  end

  // every word read matches the pattern with no loss or duplication
  a_data: assert property (@(posedge clk) disable iff (!grstb)
    rd_valid && !mode_load |-> rd_data == m_exp)
  else
  begin
    fail_count++;
    $error("FAIL %0t rd_data got %h expected %h", $time, $sampled(rd_data), $sampled(m_exp));
  end

  // word count tracks reads
  a_word_count: assert property (@(posedge clk) disable iff (!grstb)
    word_count == 16'(m_words))
  else
  begin
    fail_count++;
    $error("FAIL %0t word_count got %0d expected %0d",
           $time, $sampled(word_count), $sampled(m_words));
  end

  // no mismatch ever flagged
  a_err: assert property (@(posedge clk) disable iff (!grstb)
    err_count == '0 && !err)
  else
  begin
    fail_count++;
    $error("FAIL %0t err/err_count got %b/%0d expected 0/0",
           $time, $sampled(err), $sampled(err_count));
  end

  // full and empty follow occupancy
  a_levels: assert property (@(posedge clk) disable iff (!grstb)
    full == (m_occ == `FIFO_DEPTH) && empty == (m_occ == 0))
  else
  begin
    fail_count++;
    $error("FAIL %0t full/empty got %b/%b expected %b/%b", $time, $sampled(full),
           $sampled(empty), $sampled(m_occ) == `FIFO_DEPTH, $sampled(m_occ) == 0);
  end

  // no read output when the FIFO was empty at the accepting edge
  a_rd_empty: assert property (@(posedge clk) disable iff (!grstb)
    rd_valid |-> !$past(empty))
  else
  begin
    fail_count++;
    $error("read data came out although the FIFO was empty when the read was taken");
  end

endmodule

bind fifo_loopback_top fifo_loopback_assert i_fifo_loopback_assert (.*);

/* dv/fifo_loopback_tb.sv */
// FIFO loopback testbench
`include "fifo_settings.svh"

module fifo_loopback_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import fifo_pkg::*;

  localparam int TOTAL_WORDS = 2 * 200 + 9 * 48 + 3 * `FIFO_DEPTH; // words read, all tests
  localparam int WATCHDOG_NS = (TOTAL_WORDS * 8 + 2000) * 40;        // stream limits plus margin

  logic                    clk = 1'b0;
  logic                    grstb;
  pat_mode_t               pat_sel;
  logic [`FIFO_DATA_W-1:0] user_word;
  logic                    mode_load;
  logic                    wr_en;
  logic                    rd_en;
  logic [`FIFO_DATA_W-1:0] rd_data;
  logic                    rd_valid;
  logic                    full;
  logic                    empty;
  logic                    err;
  logic [15:0]             err_count;
  logic [15:0]             word_count;
  int                      errors = 0;       // direct check failures
  int                      tests_run = 0;
  int                      tests_failed = 0;

  fifo_loopback_top i_fifo_loopback_top (.*);

  always #20 clk = ~clk; // 40 ns period

  // drive point, 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(string name, int got, int expected);
    if (got != expected)
    begin
      errors++;
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, expected);
    end
  endtask

  function automatic int assert_fails();
    return i_fifo_loopback_top.i_fifo_loopback_assert.fail_count;
  endfunction

  task automatic report_test(string name, int fails_before);
    tests_run++;
    if (errors + assert_fails() == fails_before)
      $display("PASS %s", name);
    else
    begin
      tests_failed++;
      $display("FAIL %s", name);
    end
  endtask

  task automatic load_mode(pat_mode_t mode);
    pat_sel   = mode;
    mode_load = 1'b1;  // also flushes the FIFO
    wr_en     = 1'b0;
    rd_en     = 1'b0;
    next_cycle();
    mode_load = 1'b0;
  endtask

  // random enables until reads reaches target
  task automatic stream_words(int target, int wr_pct, int rd_pct, inout int reads);
    int cycles;
    cycles = 0;
    while (reads < target && cycles < target * 8 + 64)
    begin
      wr_en = ($urandom % 100) < wr_pct;
      rd_en = ($urandom % 100) < rd_pct;
      next_cycle();
      cycles++;
      if (rd_valid)
        reads++;
    end
    if (reads < target)
    begin
      errors++;
      $display("stream stalled, only %0d of %0d words came out", reads, target);
    end
    wr_en = 1'b0;
    rd_en = 1'b0;
  endtask

  task automatic run_test(string name, pat_mode_t mode, int n);
    int reads;
    int fails_before;
    reads = 0;
    fails_before = errors + assert_fails();
    load_mode(mode);
    stream_words(n, 70, 60, reads);
    next_cycle(); // counts lag rd_valid by a cycle
    check_value("word_count", word_count, reads);
    check_value("err_count", err_count, 0);
    report_test(name, fails_before);
  endtask

  // fill to full, drain, then keep streaming
  task automatic run_flow_test();
    int reads;
    int fails_before;
    reads = 0;
    fails_before = errors + assert_fails();
    load_mode(pat_up);
    wr_en = 1'b1;
    repeat (`FIFO_DEPTH + 4) next_cycle(); // extra writes get refused
    check_value("full", full, 1);
    stream_words(`FIFO_DEPTH, 0, 100, reads);
    check_value("empty", empty, 1);
    stream_words(3 * `FIFO_DEPTH, 70, 60, reads);
    next_cycle();
    check_value("word_count", word_count, reads);
    report_test("flow control", fails_before);
  endtask

  initial
  begin
    int fails_before;
    void'($urandom(20966));
    grstb     = 1'b0;
    pat_sel   = pat_up;
    user_word = '0;
    mode_load = 1'b0;
    wr_en     = 1'b0;
    rd_en     = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    grstb = 1'b1;
    fails_before = errors + assert_fails();
    next_cycle();
    check_value("empty", empty, 1);
    check_value("full", full, 0);
    check_value("word_count", word_count, 0);
    report_test("reset values", fails_before);
    user_word = `FIFO_DATA_W'({$urandom, $urandom, $urandom});
    run_test("up counter", pat_up, 200);     // wraps past 1023
    run_test("down counter", pat_down, 200);
    run_test("all zero", pat_zero, 48);
    run_test("all one", pat_one, 48);
    run_test("user word", pat_user, 48);
    run_test("abc constant", pat_abc, 48);
    run_test("unused code", pat_mode_t'(4'd12), 48);
    run_test("chk", pat_chk, 48);
    run_test("chkb", pat_chkb, 48);
    run_test("alt", pat_alt, 48);
    run_test("altb", pat_altb, 48);
    run_flow_test();
    $display("tests %0d, passed %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors, assert_fails());
    if (tests_failed == 0 && errors == 0 && assert_fails() == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  // watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

endmodule

/* flist.f */
+incdir+verilog
verilog/fifo_pkg.sv
verilog/pattern_gen.sv
verilog/sync_fifo.sv
verilog/pattern_check.sv
verilog/fifo_loopback_top.sv
dv/fifo_loopback_assert.sv
dv/fifo_loopback_tb.sv
